/* project.f */
logic/iir_pkg.sv
logic/lowpass_section.sv
logic/highpass_section.sv
logic/frame_output_stage.sv
logic/dual_iir_filter.sv
sim/clock_gen.sv
sim/dual_iir_filter_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the dual IIR filter testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    -f project.f \
    --top-module dual_iir_filter_tb \
    -o dual_iir_filter_sim

output="$(./obj_dir/dual_iir_filter_sim)"
echo "$output"

if grep -qx "TEST RESULT: PASS" <<< "$output"; then
    echo "Simulation passed"
    exit 0
else
    echo "Simulation failed"
    exit 1
fi

/* sim/dual_iir_filter_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module dual_iir_filter_tb;

    localparam int n_rows        = 10;
    localparam int clk_period_ns = 4;
    localparam int margin_cycles = 100;

    typedef enum int {
        pat_constant,
        pat_step,
        pat_alternate,
        pat_random,
        pat_repeat
    } pattern_e;

    // One expected output in DUT order
    typedef struct packed {
        iir_pkg::sample_t sample;
        iir_pkg::index_t  index;
        logic             done;
        logic             clipped;
        int               row;
        int               cycle;
    } expect_t;

    logic                  clk;
    logic                  rst;
    iir_pkg::sample_t      in_sample;
    logic                  in_valid;
    logic                  frame_start;
    iir_pkg::filter_mode_e mode;
    iir_pkg::sample_t      out_sample;
    logic                  out_valid;
    iir_pkg::index_t       out_index;
    logic                  frame_done;
    logic                  frame_clipped;

    ////////////////////////////////////////
    // Stimulus table with one frame per row
    ////////////////////////////////////////

    string                 row_name   [n_rows];
    iir_pkg::filter_mode_e row_mode   [n_rows];
    pattern_e              row_kind   [n_rows];
    int                    row_amp    [n_rows];
    int                    row_gap    [n_rows];
    logic                  row_toggle [n_rows];
    // Expected frame clip status as 1 or 0 and -1 when not pinned
    int                    row_clip   [n_rows];

    expect_t          exp_q[$];
    iir_pkg::sample_t last_input [iir_pkg::frame_len];
    iir_pkg::sample_t cur_out    [iir_pkg::frame_len];
    iir_pkg::sample_t prev_out   [iir_pkg::frame_len];

    // Reference model state
    int     lp_prev;
    int     hp_prev;
    logic   model_clip;

    int     cycle_count;
    int     value_errors;
    int     other_errors;
    longint watchdog_ns;

    clock_gen clk0 (
        .clk (clk),
        .rst (rst)
    );

    dual_iir_filter dut0 (
        .clk           (clk),
        .rst           (rst),
        .in_sample     (in_sample),
        .in_valid      (in_valid),
        .frame_start   (frame_start),
        .mode          (mode),
        .out_sample    (out_sample),
        .out_valid     (out_valid),
        .out_index     (out_index),
        .frame_done    (frame_done),
        .frame_clipped (frame_clipped)
    );

    task automatic set_row(input int r, input string name, input iir_pkg::filter_mode_e m,
                           input pattern_e kind, input int amp, input int gap,
                           input logic toggle, input int clip);
        row_name[r]   = name;
        row_mode[r]   = m;
        row_kind[r]   = kind;
        row_amp[r]    = amp;
        row_gap[r]    = gap;
        row_toggle[r] = toggle;
        row_clip[r]   = clip;
    endtask

    task automatic load_table();
        set_row(0, "lp_constant", iir_pkg::mode_lowpass, pat_constant, 1000, 0, 1'b0, 0);
        set_row(1, "hp_step", iir_pkg::mode_highpass, pat_step, 1500, 0, 1'b0, -1);
        set_row(2, "lp_full_negative", iir_pkg::mode_lowpass, pat_constant, -2048, 0, 1'b0, 1);
        set_row(3, "hp_alternate", iir_pkg::mode_highpass, pat_alternate, 2047, 0, 1'b0, 1);
        set_row(4, "lp_alternate", iir_pkg::mode_lowpass, pat_alternate, 2047, 2, 1'b0, -1);
        set_row(5, "lp_low_random", iir_pkg::mode_lowpass, pat_random, 100, 3, 1'b0, 0);
        // Same samples again so a cleared state repeats the outputs
        set_row(6, "lp_low_repeat", iir_pkg::mode_lowpass, pat_repeat, 0, 1, 1'b0, 0);
        set_row(7, "hp_mode_toggle", iir_pkg::mode_highpass, pat_random, 800, 2, 1'b1, -1);
        set_row(8, "lp_after_toggle", iir_pkg::mode_lowpass, pat_step, 600, 1, 1'b1, -1);
        set_row(9, "hp_random_gaps", iir_pkg::mode_highpass, pat_random, 2047, 5, 1'b0, -1);
    endtask

    function automatic longint run_limit_ns();
        int max_gap;
        max_gap = 0;
        for (int r = 0; r < n_rows; r++) begin
            if (row_gap[r] > max_gap) begin
                max_gap = row_gap[r];
            end
        end
        return longint'(n_rows * iir_pkg::frame_len) * (1 + max_gap) * clk_period_ns
               + margin_cycles * clk_period_ns;
    endfunction

    ////////////////////////////////////////
    // Compare tasks
    ////////////////////////////////////////

    task automatic check_sample(input string name, input string what,
                                input iir_pkg::sample_t exp, input iir_pkg::sample_t act);
        if (exp !== act) begin
            value_errors++;
            $display("[ERROR] %s: %s expected %0d, actual %0d", name, what, exp, act);
        end
    endtask

    task automatic check_index(input string name, input iir_pkg::index_t exp,
                               input iir_pkg::index_t act);
        if (exp !== act) begin
            value_errors++;
            $display("[ERROR] %s: out_index expected %0d, actual %0d", name, exp, act);
        end
    endtask

    task automatic check_flag(input string name, input string what,
                              input logic exp, input logic act);
        if (exp !== act) begin
            value_errors++;
            $display("[ERROR] %s: %s expected %b, actual %b", name, what, exp, act);
        end
    endtask

    task automatic check_latency(input string name, input int exp, input int act);
        if (exp != act) begin
            value_errors++;
            $display("[ERROR] %s: out_valid cycle expected %0d, actual %0d", name, exp, act);
        end
    endtask

    ////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////

    function automatic int saturate(input int v);
        if (v > iir_pkg::sample_max) begin
            return iir_pkg::sample_max;
        end else if (v < iir_pkg::sample_min) begin
            return iir_pkg::sample_min;
        end
        return v;
    endfunction

    task automatic predict(input int r, input int i, input iir_pkg::sample_t x);
        int      xi;
        int      lp_raw;
        int      lp_y;
        int      t_raw;
        int      t;
        int      d;
        int      hp_y;
        logic    lp_hit;
        logic    hp_hit;
        logic    sel_hit;
        expect_t e;
        xi = x;
        if (i == 0) begin
            lp_prev = 0;
            hp_prev = 0;
        end
        lp_raw = (iir_pkg::coef_fwd * xi + iir_pkg::coef_fb * lp_prev) >>> iir_pkg::frac_bits;
        lp_y   = saturate(lp_raw);
        lp_hit = (lp_y != lp_raw);
        // High-pass is x minus the smoothed term
        t_raw  = (iir_pkg::coef_fb * xi + iir_pkg::coef_fb * hp_prev) >>> iir_pkg::frac_bits;
        t      = saturate(t_raw);
        d      = xi - t;
        hp_y   = saturate(d);
        hp_hit = (t != t_raw) || (hp_y != d);
        lp_prev = lp_y;
        hp_prev = hp_y;
        // Path is fixed by the mode at frame start
        if (row_mode[r] == iir_pkg::mode_highpass) begin
            e.sample = iir_pkg::sample_t'(hp_y);
            sel_hit  = hp_hit;
        end else begin
            e.sample = iir_pkg::sample_t'(lp_y);
            sel_hit  = lp_hit;
        end
        model_clip = (i == 0) ? sel_hit : (model_clip | sel_hit);
        e.index    = iir_pkg::index_t'(i);
        e.done     = (i == iir_pkg::frame_len - 1);
        e.clipped  = model_clip;
        e.row      = r;
        // Sections capture on the next edge and the monitor sees it two edges later
        e.cycle    = cycle_count + 3;
        exp_q.push_back(e);
        if (e.done && row_clip[r] >= 0 && model_clip != (row_clip[r] != 0)) begin
            other_errors++;
            $display("Reference model clip status for %s is not the saturation intended",
                     row_name[r]);
        end
    endtask

    function automatic iir_pkg::sample_t next_input(input int r, input int i);
        int v;
        case (row_kind[r])
            pat_constant:  v = row_amp[r];
            pat_step:      v = (i < iir_pkg::frame_len / 2) ? -row_amp[r] : row_amp[r];
            // Sign flips each sample with a repeat every 17
            pat_alternate: v = (((i % 17) % 2) == 0) ? row_amp[r] : -row_amp[r] - 1;
            pat_random:    v = int'($urandom_range(2 * row_amp[r])) - row_amp[r];
            default:       v = last_input[i];
        endcase
        return iir_pkg::sample_t'(v);
    endfunction

    function automatic iir_pkg::filter_mode_e other_mode(input iir_pkg::filter_mode_e m);
        return (m == iir_pkg::mode_lowpass) ? iir_pkg::mode_highpass : iir_pkg::mode_lowpass;
    endfunction

    task automatic run_frame(input int r);
        int               idle;
        iir_pkg::sample_t x;
        for (int i = 0; i < iir_pkg::frame_len; i++) begin
            idle = int'($urandom_range(row_gap[r]));
            repeat (idle) begin
                @(negedge clk);
                in_valid    = 1'b0;
                frame_start = 1'b0;
            end
            x = next_input(r, i);
            last_input[i] = x;
            @(negedge clk);
            in_sample   = x;
            in_valid    = 1'b1;
            frame_start = (i == 0);
            if (i == 0) begin
                mode = row_mode[r];
            end else if (row_toggle[r] && i == iir_pkg::frame_len / 2) begin
                // Mid-frame change only takes effect at the next frame
                mode = other_mode(row_mode[r]);
            end
            predict(r, i, x);
        end
    endtask

    ////////////////////////////////////////
    // Output monitor
    ////////////////////////////////////////

    always @(posedge clk) begin
        expect_t e;
        string   name;
        cycle_count = cycle_count + 1;
        if (!rst && out_valid) begin
            if (exp_q.size() == 0) begin
                other_errors++;
                $display("out_valid was high at cycle %0d with no output expected", cycle_count);
            end else begin
                e    = exp_q.pop_front();
                name = row_name[e.row];
                check_latency(name, e.cycle, cycle_count);
                check_sample(name, "out_sample", e.sample, out_sample);
                check_index(name, e.index, out_index);
                check_flag(name, "frame_done", e.done, frame_done);
                if (e.done) begin
                    check_flag(name, "frame_clipped", e.clipped, frame_clipped);
                end
                if (row_kind[e.row] == pat_repeat) begin
                    check_sample(name, "repeat of previous frame", prev_out[e.index], out_sample);
                end
                // Model outputs of this frame for a later repeat
                cur_out[e.index] = e.sample;
                if (e.done) begin
                    prev_out = cur_out;
                end
            end
        end
    end

    initial begin
        wait (watchdog_ns > 0);
        #(watchdog_ns);
        $display("Timeout after %0d ns, the run did not complete", watchdog_ns);
        $display("TEST RESULT: FAIL");
        $finish;
    end

    initial begin
        in_sample    = '0;
        in_valid     = 1'b0;
        frame_start  = 1'b0;
        mode         = iir_pkg::mode_lowpass;
        lp_prev      = 0;
        hp_prev      = 0;
        model_clip   = 1'b0;
        cycle_count  = 0;
        value_errors = 0;
        other_errors = 0;
        watchdog_ns  = 0;
        void'($urandom(32'hbefc_eb84));
        load_table();
        watchdog_ns = run_limit_ns();

        @(negedge rst);
        @(negedge clk);
        for (int r = 0; r < n_rows; r++) begin
            run_frame(r);
        end
        @(negedge clk);
        in_valid    = 1'b0;
        frame_start = 1'b0;

        // Pipeline is two cycles deep
        repeat (6) @(posedge clk);
        if (exp_q.size() != 0) begin
            other_errors += exp_q.size();
            $display("%0d expected outputs never appeared on out_valid", exp_q.size());
        end

        $display("Errors: %0d value mismatches, %0d other failures", value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* sim/clock_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module clock_gen (
    output logic clk,
    output logic rst
);

    localparam int half_period_ns = 2;
    localparam int reset_cycles   = 5;

    // 4 ns period
    initial begin
        clk = 1'b0;
        forever #(half_period_ns) clk = ~clk;
    end

    // Released on a rising edge, so the DUT sees it on 5 edges
    initial begin
        rst = 1'b1;
        repeat (reset_cycles) @(posedge clk);
        rst <= 1'b0;
    end

endmodule

`default_nettype wire

/* logic/dual_iir_filter.sv */
`timescale 1ns/1ps
`default_nettype none

module dual_iir_filter (
    input  logic                  clk,
    input  logic                  rst,
    input  iir_pkg::sample_t      in_sample,
    input  logic                  in_valid,
    input  logic                  frame_start,
    input  iir_pkg::filter_mode_e mode,
    output iir_pkg::sample_t      out_sample,
    output logic                  out_valid,
    output iir_pkg::index_t       out_index,
    output logic                  frame_done,
    output logic                  frame_clipped
);

    iir_pkg::sample_t lp_y;
    logic             lp_valid;
    logic             lp_clip;
    iir_pkg::sample_t hp_y;
    logic             hp_valid;
    logic             hp_clip;

    ////////////////////////////////////////
    // Filter sections, both see every sample
    ////////////////////////////////////////

    lowpass_section lp0 (
        .clk         (clk),
        .rst         (rst),
        .in_sample   (in_sample),
        .in_valid    (in_valid),
        .frame_start (frame_start),
        .y           (lp_y),
        .y_valid     (lp_valid),
        .y_clip      (lp_clip)
    );

    highpass_section hp0 (
        .clk         (clk),
        .rst         (rst),
        .in_sample   (in_sample),
        .in_valid    (in_valid),
        .frame_start (frame_start),
        .y           (hp_y),
        .y_valid     (hp_valid),
        .y_clip      (hp_clip)
    );

    // Mode and frame start are delayed inside the stage
    frame_output_stage out0 (
        .clk           (clk),
        .rst           (rst),
        .mode          (mode),
        .frame_start   (frame_start),
        .lp_y          (lp_y),
        .hp_y          (hp_y),
        .lp_valid      (lp_valid),
        .hp_valid      (hp_valid),
        .lp_clip       (lp_clip),
        .hp_clip       (hp_clip),
        .out_sample    (out_sample),
        .out_valid     (out_valid),
        .out_index     (out_index),
        .frame_done    (frame_done),
        .frame_clipped (frame_clipped)
    );

endmodule

`default_nettype wire

/* logic/frame_output_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module frame_output_stage (
    input  logic                  clk,
    input  logic                  rst,
    input  iir_pkg::filter_mode_e mode,
    input  logic                  frame_start,
    input  iir_pkg::sample_t      lp_y,
    input  iir_pkg::sample_t      hp_y,
    input  logic                  lp_valid,
    input  logic                  hp_valid,
    input  logic                  lp_clip,
    input  logic                  hp_clip,
    output iir_pkg::sample_t      out_sample,
    output logic                  out_valid,
    output iir_pkg::index_t       out_index,
    output logic                  frame_done,
    output logic                  frame_clipped
);

    logic                  start_d;
    iir_pkg::filter_mode_e mode_d;
    iir_pkg::filter_mode_e mode_q;
    iir_pkg::filter_mode_e sel_mode;
    logic                  first;
    logic                  sel_clip;
    iir_pkg::index_t       next_index;

    ////////////////////////////////////////
    // Align frame start and mode with sections
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            start_d <= 1'b0;
        end else begin
            start_d <= frame_start;
        end
    end

    always_ff @(posedge clk) begin
        mode_d <= mode;
    end

    // First sample of a frame already uses the new mode
    assign first    = lp_valid & start_d;
    assign sel_mode = first ? mode_d : mode_q;
    assign sel_clip = (sel_mode == iir_pkg::mode_highpass) ? hp_clip : lp_clip;

    assign next_index = first ? '0 : out_index + 1'b1;

    always_ff @(posedge clk) begin
        if (rst) begin
            mode_q <= iir_pkg::mode_lowpass;
        end else if (first) begin
            mode_q <= mode_d;
        end
    end

    ////////////////////////////////////////
    // Registered outputs
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid     <= 1'b0;
            out_index     <= '0;
            frame_done    <= 1'b0;
            frame_clipped <= 1'b0;
        end else begin
            out_valid  <= lp_valid;
            frame_done <= lp_valid &&
                          (next_index == iir_pkg::index_t'(iir_pkg::frame_len - 1));
            if (lp_valid) begin
                out_index <= next_index;
                // Sticky over the frame, restarts on its first sample
                frame_clipped <= first ? sel_clip : (frame_clipped | sel_clip);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (lp_valid) begin
            out_sample <= (sel_mode == iir_pkg::mode_highpass) ? hp_y : lp_y;
        end
    end

    assert property (@(posedge clk) disable iff (rst) frame_done |-> out_valid)
        else $error("frame_output_stage: frame_done without out_valid");

    // Both sections must stay in step
    assert property (@(posedge clk) disable iff (rst) lp_valid == hp_valid)
        else $error("frame_output_stage: section valid strobes differ");

endmodule

`default_nettype wire

/* logic/highpass_section.sv */
`timescale 1ns/1ps
`default_nettype none

module highpass_section (
    input  logic             clk,
    input  logic             rst,
    input  iir_pkg::sample_t in_sample,
    input  logic             in_valid,
    input  logic             frame_start,
    output iir_pkg::sample_t y,
    output logic             y_valid,
    output logic             y_clip
);

    iir_pkg::sample_t                 prev_y;
    logic signed [iir_pkg::acc_w-1:0] acc;
    logic signed [iir_pkg::acc_w-1:0] scaled;
    iir_pkg::sample_t                 t;
    logic                             t_clip;
    logic signed [iir_pkg::sample_w:0] diff;
    iir_pkg::sample_t                 y_next;
    logic                             diff_clip;

    ////////////////////////////////////////
    // Smoothed term t from x and own output
    ////////////////////////////////////////

    always_comb begin
        prev_y = frame_start ? '0 : y;
        // Same weight on both terms
        acc    = iir_pkg::coef_fb * in_sample + iir_pkg::coef_fb * prev_y;
        scaled = acc >>> iir_pkg::frac_bits;

        if (scaled > iir_pkg::sample_max) begin
            t      = iir_pkg::sample_t'(iir_pkg::sample_max);
            t_clip = 1'b1;
        end else if (scaled < iir_pkg::sample_min) begin
            t      = iir_pkg::sample_t'(iir_pkg::sample_min);
            t_clip = 1'b1;
        end else begin
            t      = iir_pkg::sample_t'(scaled);
            t_clip = 1'b0;
        end
    end

    ////////////////////////////////////////
    // Output y = x - t, second clip
    ////////////////////////////////////////

    always_comb begin
        // One extra bit, range is about +-4095
        diff = in_sample - t;

        if (diff > iir_pkg::sample_max) begin
            y_next    = iir_pkg::sample_t'(iir_pkg::sample_max);
            diff_clip = 1'b1;
        end else if (diff < iir_pkg::sample_min) begin
            y_next    = iir_pkg::sample_t'(iir_pkg::sample_min);
            diff_clip = 1'b1;
        end else begin
            y_next    = iir_pkg::sample_t'(diff);
            diff_clip = 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            y_valid <= 1'b0;
        end else begin
            y_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid) begin
            y      <= y_next;
            y_clip <= t_clip | diff_clip;
        end
    end

    assert property (@(posedge clk) disable iff (rst)
                     !$past(rst) |-> (y_valid == $past(in_valid)))
        else $error("highpass_section: y_valid not one cycle behind in_valid");

endmodule

`default_nettype wire

/* logic/lowpass_section.sv */
`timescale 1ns/1ps
`default_nettype none

module lowpass_section (
    input  logic             clk,
    input  logic             rst,
    input  iir_pkg::sample_t in_sample,
    input  logic             in_valid,
    input  logic             frame_start,
    output iir_pkg::sample_t y,
    output logic             y_valid,
    output logic             y_clip
);

    iir_pkg::sample_t                 prev_y;
    logic signed [iir_pkg::acc_w-1:0] acc;
    logic signed [iir_pkg::acc_w-1:0] scaled;
    iir_pkg::sample_t                 y_next;
    logic                             clip_next;

    ////////////////////////////////////////
    // Recurrence y = 0.1 x + 0.9 y_prev
    ////////////////////////////////////////

    always_comb begin
        // Registered output is the filter state
        prev_y = frame_start ? '0 : y;
        acc    = iir_pkg::coef_fwd * in_sample + iir_pkg::coef_fb * prev_y;
        // Arithmetic shift, rounds toward minus infinity
        scaled = acc >>> iir_pkg::frac_bits;

        if (scaled > iir_pkg::sample_max) begin
            y_next    = iir_pkg::sample_t'(iir_pkg::sample_max);
            clip_next = 1'b1;
        end else if (scaled < iir_pkg::sample_min) begin
            y_next    = iir_pkg::sample_t'(iir_pkg::sample_min);
            clip_next = 1'b1;
        end else begin
            y_next    = iir_pkg::sample_t'(scaled);
            clip_next = 1'b0;
        end
    end

    ////////////////////////////////////////
    // Output registers
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            y_valid <= 1'b0;
        end else begin
            y_valid <= in_valid;
        end
    end

    // State only moves on a real sample, gaps hold it
    always_ff @(posedge clk) begin
        if (in_valid) begin
            y      <= y_next;
            y_clip <= clip_next;
        end
    end

    assert property (@(posedge clk) rst |=> !y_valid)
        else $error("lowpass_section: y_valid high on the cycle after reset");

endmodule

`default_nettype wire

/* logic/iir_pkg.sv */
`default_nettype none

package iir_pkg;

    ////////////////////////////////////////
    // Sample format
    ////////////////////////////////////////

    localparam int sample_w = 12;

    typedef logic signed [sample_w-1:0] sample_t;

    // Symmetric clip range, -2048 never produced
    localparam int sample_max = 2047;
    localparam int sample_min = -2047;

    ////////////////////////////////////////
    // Fixed-point coefficients, Q1.11
    ////////////////////////////////////////

    localparam int frac_bits = 11;

    // Roughly 0.1 and 0.9 of 2**11
    localparam int coef_fwd = 205;
    localparam int coef_fb  = 1843;

    // Holds both full-precision products and their sum
    localparam int acc_w = 32;

    ////////////////////////////////////////
    // Framing
    ////////////////////////////////////////

    localparam int frame_len = 256;
    localparam int index_w   = 8;

    typedef logic [index_w-1:0] index_t;

    // Result selected by the output stage
    typedef enum logic {
        mode_lowpass  = 1'b0,
        mode_highpass = 1'b1
    } filter_mode_e;

endpackage

`default_nettype wire
